/* hw/i2c_consts.svh */
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// one byte on the bus
`define I2C_DATA_W 8

// width of the divider that sets a quarter scl period
`define I2C_CNT_W 16

// flops on each line input before it is used
`define I2C_SYNC_STAGES 2

`endif

/* hw/i2c_pkg.sv */
`include "i2c_consts.svh"

package i2c_pkg;

	// opcodes from the byte sequencer to the bit controller
	typedef enum logic [2:0] {
		CMD_NOP   = 3'd0,
		CMD_START = 3'd1,
		CMD_STOP  = 3'd2,
		CMD_WRITE = 3'd3,
		CMD_READ  = 3'd4
	} bit_cmd_e;

	typedef struct packed {
		logic                   start;
		logic                   stop;
		logic                   read;
		logic                   write;
		logic                   ack_in;  // ack level sent after a read
		logic [`I2C_DATA_W-1:0] din;
	} byte_cmd_t;

	typedef struct packed {
		logic                   ack_out;  // level seen in the ack slot
		logic [`I2C_DATA_W-1:0] dout;
	} byte_rsp_t;

	typedef enum logic [2:0] {ST_IDLE, ST_START, ST_WRITE, ST_READ, ST_ACK, ST_STOP} byte_state_e;

	// quarter phases of every bit command
	typedef enum logic [4:0] {
		BS_IDLE,
		BS_START_A, BS_START_B, BS_START_C, BS_START_D, BS_START_E,
		BS_STOP_A, BS_STOP_B, BS_STOP_C, BS_STOP_D,
		BS_WR_A, BS_WR_B, BS_WR_C, BS_WR_D,
		BS_RD_A, BS_RD_B, BS_RD_C, BS_RD_D
	} bit_state_e;

endpackage

/* hw/i2c_clk_timer.sv */
`timescale 1ns/100ps
`include "i2c_consts.svh"

module i2c_clk_timer (
	input  logic                  clk,
	input  logic                  nReset,
	input  logic                  ena_i,
	input  logic [`I2C_CNT_W-1:0] clk_cnt_i,
	input  logic                  reload_i,
	input  logic                  stretch_i,
	output logic                  tick_o
);

	logic [`I2C_CNT_W-1:0] cnt;
	logic                  run;

	assign run = ena_i & ~stretch_i;  // a stretching slave freezes the count

	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
			cnt <= '0;
		else if (reload_i)
			cnt <= clk_cnt_i;  // fresh quarter period
		else if (run)
		begin
			if (cnt == '0)
				cnt <= clk_cnt_i;
			else
				cnt <= cnt - 1'b1;
		end
	end

	// one tick per clk_cnt_i+1 running cycles
	assign tick_o = run & ~reload_i & (cnt == '0);

	// ticks can only sit back to back with a zero divider
	a_tick_spacing: assert property (@(posedge clk) disable iff (!nReset)
		(tick_o && clk_cnt_i != '0) |=> !tick_o)
	else
		$error("tick in two consecutive cycles with divider %0d", clk_cnt_i);

endmodule

/* hw/i2c_bit_ctrl.sv */
`timescale 1ns/100ps
`include "i2c_consts.svh"

module i2c_bit_ctrl (
	input  logic              clk,
	input  logic              nReset,
	input  logic              tick_i,
	input  i2c_pkg::bit_cmd_e cmd_i,
	input  logic              txd_i,
	output logic              ack_o,
	output logic              rxd_o,
	output logic              al_o,
	output logic              bus_busy_o,
	output logic              stretch_o,
	output logic              reload_o,
	input  logic              scl_i,
	input  logic              sda_i,
	output logic              scl_oen_o,
	output logic              sda_oen_o
);
	import i2c_pkg::*;

	logic [`I2C_SYNC_STAGES-1:0] scl_sync;
	logic [`I2C_SYNC_STAGES-1:0] sda_sync;
	logic                        scl_s;
	logic                        sda_s;
	logic                        sda_prev;
	logic                        start_det;
	logic                        sto_det;
	logic                        al_det;
	logic                        stop_req;  // last accepted opcode was our own STOP
	bit_state_e                  state;

	// line synchronisers start at the idle high level
	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			scl_sync <= '1;
			sda_sync <= '1;
			sda_prev <= 1'b1;
		end
		else
		begin
			scl_sync <= {scl_sync[`I2C_SYNC_STAGES-2:0], scl_i};
			sda_sync <= {sda_sync[`I2C_SYNC_STAGES-2:0], sda_i};
			sda_prev <= sda_s;
		end
	end

	assign scl_s = scl_sync[`I2C_SYNC_STAGES-1];
	assign sda_s = sda_sync[`I2C_SYNC_STAGES-1];

	// sda edges while scl is high
	assign start_det = scl_s & sda_prev & ~sda_s;
	assign sto_det   = scl_s & ~sda_prev & sda_s;

	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
			bus_busy_o <= 1'b0;
		else if (start_det)
			bus_busy_o <= 1'b1;
		else if (sto_det)
			bus_busy_o <= 1'b0;
	end

	// released sda read low during scl high, or someone else's STOP mid command
	assign al_det = ((state inside {BS_WR_B, BS_WR_C}) & scl_s & sda_oen_o & ~sda_s) |
		(sto_det & ~stop_req & (state != BS_IDLE));

	assign stretch_o = scl_oen_o & ~scl_s;  // scl released but still held low
	assign reload_o  = (state == BS_IDLE) | al_det;

	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			state     <= BS_IDLE;
			scl_oen_o <= 1'b1;
			sda_oen_o <= 1'b1;
			ack_o     <= 1'b0;
			al_o      <= 1'b0;
			rxd_o     <= 1'b0;
			stop_req  <= 1'b0;
		end
		else if (al_det)
		begin
			state     <= BS_IDLE;
			scl_oen_o <= 1'b1;  // let go of both lines
			sda_oen_o <= 1'b1;
			al_o      <= 1'b1;
		end
		else
		begin
			ack_o <= 1'b0;
			al_o  <= 1'b0;
			case (state)
			BS_IDLE:
				// the opcode still shows the finished command while ack or al is out
				if (!ack_o && !al_o && cmd_i != CMD_NOP)
				begin
					stop_req <= (cmd_i == CMD_STOP);
					case (cmd_i)
					CMD_START:
					begin
						state     <= BS_START_A;
						sda_oen_o <= 1'b1;  // scl stays where it is
					end
					CMD_STOP:
					begin
						state     <= BS_STOP_A;
						scl_oen_o <= 1'b0;
						sda_oen_o <= 1'b0;
					end
					CMD_WRITE:
					begin
						state     <= BS_WR_A;
						scl_oen_o <= 1'b0;
						sda_oen_o <= txd_i;
					end
					default:
					begin
						state     <= BS_RD_A;
						scl_oen_o <= 1'b0;
						sda_oen_o <= 1'b1;
					end
					endcase
				end
			BS_START_A:
				if (tick_i)
				begin
					state     <= BS_START_B;
					scl_oen_o <= 1'b1;
				end
			BS_START_B:
				if (tick_i)
				begin
					state     <= BS_START_C;
					sda_oen_o <= 1'b0;  // START itself
				end
			BS_START_C:
				if (tick_i)
					state <= BS_START_D;
			BS_START_D:
				if (tick_i)
				begin
					state     <= BS_START_E;
					scl_oen_o <= 1'b0;
				end
			BS_STOP_A:
				if (tick_i)
				begin
					state     <= BS_STOP_B;
					scl_oen_o <= 1'b1;
				end
			BS_STOP_B:
				if (tick_i)
					state <= BS_STOP_C;
			BS_STOP_C:
				if (tick_i)
				begin
					state     <= BS_STOP_D;
					sda_oen_o <= 1'b1;  // sda rises with scl high
				end
			BS_WR_A, BS_RD_A:
				if (tick_i)
				begin
					state     <= (state == BS_WR_A) ? BS_WR_B : BS_RD_B;
					scl_oen_o <= 1'b1;  // slave may stretch from here
				end
			BS_WR_B, BS_RD_B:
				if (tick_i)
					state <= (state == BS_WR_B) ? BS_WR_C : BS_RD_C;
			BS_WR_C, BS_RD_C:
				if (tick_i)
				begin
					state     <= (state == BS_WR_C) ? BS_WR_D : BS_RD_D;
					scl_oen_o <= 1'b0;
					rxd_o     <= sda_s;  // end of scl high
				end
			BS_START_E, BS_STOP_D, BS_WR_D, BS_RD_D:
				if (tick_i)
				begin
					state <= BS_IDLE;
					ack_o <= 1'b1;
				end
			default:
				state <= BS_IDLE;
			endcase
		end
	end

	a_ack_al_excl: assert property (@(posedge clk) disable iff (!nReset) !(ack_o && al_o))
	else
		$error("bit ack and arbitration loss together");

endmodule

/* hw/i2c_shift_reg.sv */
`timescale 1ns/100ps
`include "i2c_consts.svh"

module i2c_shift_reg (
	input  logic                   clk,
	input  logic                   nReset,
	input  logic                   load_i,
	input  logic                   shift_i,
	input  logic [`I2C_DATA_W-1:0] din_i,
	input  logic                   rxd_i,
	output logic [`I2C_DATA_W-1:0] dout_o,
	output logic                   msb_o,
	output logic                   last_bit_o
);

	localparam int CNT_W = $clog2(`I2C_DATA_W);

	logic [`I2C_DATA_W-1:0] sr;
	logic [CNT_W-1:0]       cnt;  // bits still to go after the current one

	always_ff @(posedge clk)
	begin
		if (load_i)
			sr <= din_i;
		else if (shift_i)
			sr <= {sr[`I2C_DATA_W-2:0], rxd_i};  // msb first on the wire
	end

	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
			cnt <= '0;
		else if (load_i)
			cnt <= CNT_W'(`I2C_DATA_W - 1);
		else if (shift_i)
			cnt <= cnt - 1'b1;
	end

	assign dout_o     = sr;
	assign msb_o      = sr[`I2C_DATA_W-1];
	assign last_bit_o = (cnt == '0);

	a_load_shift: assert property (@(posedge clk) disable iff (!nReset) !(load_i && shift_i))
	else
		$error("load and shift in the same cycle");

endmodule

/* hw/i2c_byte_ctrl.sv */
`timescale 1ns/100ps

module i2c_byte_ctrl (
	input  logic               clk,
	input  logic               nReset,
	input  i2c_pkg::byte_cmd_t cmd_i,
	output logic               cmd_ack_o,
	output logic               ack_out_o,
	output logic               busy_o,
	output i2c_pkg::bit_cmd_e  bit_cmd_o,
	output logic               bit_txd_o,
	input  logic               bit_ack_i,
	input  logic               bit_rxd_i,
	input  logic               al_i,
	output logic               load_o,
	output logic               shift_o,
	input  logic               msb_i,
	input  logic               last_bit_i
);
	import i2c_pkg::*;

	byte_state_e state;
	logic        go;

	// held command is masked in the cycle of its own acknowledge
	assign go = (cmd_i.read | cmd_i.write | cmd_i.stop) & ~cmd_ack_o;

	assign busy_o = (state != ST_IDLE);

	// load right as the first data bit is issued so txd is valid on the next cycle
	assign load_o  = ((state == ST_IDLE) & go) | ((state == ST_START) & bit_ack_i);
	assign shift_o = ((state == ST_WRITE) | (state == ST_READ)) & bit_ack_i;

	assign bit_txd_o = (state == ST_ACK) ? cmd_i.ack_in : msb_i;  // ack slot after a read

	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			state     <= ST_IDLE;
			bit_cmd_o <= CMD_NOP;
			cmd_ack_o <= 1'b0;
			ack_out_o <= 1'b0;
		end
		else if (al_i)
		begin
			state     <= ST_IDLE;  // command dropped without cmd_ack
			bit_cmd_o <= CMD_NOP;
			cmd_ack_o <= 1'b0;
		end
		else
		begin
			cmd_ack_o <= 1'b0;
			case (state)
			ST_IDLE:
				if (go)
				begin
					if (cmd_i.start)
					begin
						state     <= ST_START;
						bit_cmd_o <= CMD_START;
					end
					else if (cmd_i.read)
					begin
						state     <= ST_READ;
						bit_cmd_o <= CMD_READ;
					end
					else if (cmd_i.write)
					begin
						state     <= ST_WRITE;
						bit_cmd_o <= CMD_WRITE;
					end
					else
					begin
						state     <= ST_STOP;  // bare stop
						bit_cmd_o <= CMD_STOP;
					end
				end
			ST_START:
				if (bit_ack_i)
				begin
					state     <= cmd_i.read ? ST_READ : ST_WRITE;
					bit_cmd_o <= cmd_i.read ? CMD_READ : CMD_WRITE;
				end
			ST_WRITE:
				if (bit_ack_i && last_bit_i)
				begin
					state     <= ST_ACK;
					bit_cmd_o <= CMD_READ;  // sample the slave's ack
				end
			ST_READ:
				if (bit_ack_i && last_bit_i)
				begin
					state     <= ST_ACK;
					bit_cmd_o <= CMD_WRITE;  // send ack_in
				end
			ST_ACK:
				if (bit_ack_i)
				begin
					ack_out_o <= bit_rxd_i;
					if (cmd_i.stop)
					begin
						state     <= ST_STOP;
						bit_cmd_o <= CMD_STOP;
					end
					else
					begin
						state     <= ST_IDLE;
						bit_cmd_o <= CMD_NOP;
						cmd_ack_o <= 1'b1;
					end
				end
			ST_STOP:
				if (bit_ack_i)
				begin
					state     <= ST_IDLE;
					bit_cmd_o <= CMD_NOP;
					cmd_ack_o <= 1'b1;
				end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	a_cmd_ack_pulse: assert property (@(posedge clk) disable iff (!nReset)
		cmd_ack_o |=> !cmd_ack_o)
	else
		$error("cmd_ack held for more than one cycle");

endmodule

/* hw/i2c_master_top.sv */
`timescale 1ns/100ps
`include "i2c_consts.svh"

module i2c_master_top (
	input  logic                  clk,
	input  logic                  nReset,
	input  logic                  ena_i,
	input  logic [`I2C_CNT_W-1:0] clk_cnt_i,
	input  i2c_pkg::byte_cmd_t    cmd_i,
	output logic                  cmd_ack_o,
	output i2c_pkg::byte_rsp_t    rsp_o,
	output logic                  busy_o,
	output logic                  al_o,
	output logic                  bus_busy_o,
	input  logic                  scl_i,
	input  logic                  sda_i,
	output logic                  scl_oen_o,
	output logic                  sda_oen_o
);
	import i2c_pkg::*;

	logic                   tick;
	logic                   stretch;
	logic                   reload;
	bit_cmd_e               bit_cmd;
	logic                   bit_txd;
	logic                   bit_ack;
	logic                   bit_rxd;
	logic                   load;
	logic                   shift;
	logic                   msb;
	logic                   last_bit;
	logic                   ack_out;
	logic [`I2C_DATA_W-1:0] dout;

	assign rsp_o = '{ack_out: ack_out, dout: dout};

	i2c_clk_timer u_clk_timer (
		.clk       (clk),
		.nReset    (nReset),
		.ena_i     (ena_i),
		.clk_cnt_i (clk_cnt_i),
		.reload_i  (reload),
		.stretch_i (stretch),
		.tick_o    (tick)
	);

	i2c_bit_ctrl u_bit_ctrl (
		.clk        (clk),
		.nReset     (nReset),
		.tick_i     (tick),
		.cmd_i      (bit_cmd),
		.txd_i      (bit_txd),
		.ack_o      (bit_ack),
		.rxd_o      (bit_rxd),
		.al_o       (al_o),
		.bus_busy_o (bus_busy_o),
		.stretch_o  (stretch),
		.reload_o   (reload),
		.scl_i      (scl_i),
		.sda_i      (sda_i),
		.scl_oen_o  (scl_oen_o),
		.sda_oen_o  (sda_oen_o)
	);

	i2c_shift_reg u_shift_reg (
		.clk        (clk),
		.nReset     (nReset),
		.load_i     (load),
		.shift_i    (shift),
		.din_i      (cmd_i.din),
		.rxd_i      (bit_rxd),
		.dout_o     (dout),
		.msb_o      (msb),
		.last_bit_o (last_bit)
	);

	i2c_byte_ctrl u_byte_ctrl (
		.clk        (clk),
		.nReset     (nReset),
		.cmd_i      (cmd_i),
		.cmd_ack_o  (cmd_ack_o),
		.ack_out_o  (ack_out),
		.busy_o     (busy_o),
		.bit_cmd_o  (bit_cmd),
		.bit_txd_o  (bit_txd),
		.bit_ack_i  (bit_ack),
		.bit_rxd_i  (bit_rxd),
		.al_i       (al_o),
		.load_o     (load),
		.shift_o    (shift),
		.msb_i      (msb),
		.last_bit_i (last_bit)
	);

endmodule

/* verif/i2c_slave_model.sv */
`timescale 1ns/100ps

module i2c_slave_model (
	input  logic clk,
	input  logic nReset,
	input  logic scl_i,
	input  logic sda_i,
	input  logic force_sda_low_i,
	output logic scl_low_o,
	output logic sda_low_o
);

	logic [7:0] rd_q[$];    // bytes to return on reads
	logic       nack_q[$];  // one bit per received byte where 1 means nack
	logic [7:0] rx_q[$];    // bytes seen from the master
	logic       mack_q[$];  // master ack level after each read byte
	integer     seed;
	logic       scl_d, sda_d;
	logic       active, addr_phase, rd_mode, ack_slot, nack;
	logic       sda_drv;
	logic [7:0] sh, tx;
	logic [31:0] rv;
	int         bitcnt;
	int         hold;

	assign sda_low_o = sda_drv | force_sda_low_i;
	assign scl_low_o = (hold != 0);

	initial seed = 24;

	always @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			scl_d = 1'b1;
			sda_d = 1'b1;
			active = 1'b0;
			ack_slot = 1'b0;
			sda_drv <= 1'b0;
			hold <= 0;
		end
		else
		begin
			if (hold != 0)
				hold <= hold - 1;
			if (scl_i && scl_d && sda_d && !sda_i)
			begin
				active = 1'b1;  // start so the address byte follows
				addr_phase = 1'b1;
				rd_mode = 1'b0;
				ack_slot = 1'b0;
				bitcnt = 0;
				sda_drv <= 1'b0;
			end
			else if (scl_i && scl_d && !sda_d && sda_i)
			begin
				active = 1'b0;  // stop
				sda_drv <= 1'b0;
			end
			else if (active && scl_i && !scl_d)
			begin
				if (ack_slot)
				begin
					if (rd_mode)
					begin
						mack_q.push_back(sda_i);
						nack = sda_i;
					end
				end
				else
				begin
					bitcnt++;
					if (!rd_mode)
					begin
						sh = {sh[6:0], sda_i};
						if (bitcnt == 8)
						begin
							rx_q.push_back(sh);
							nack = (nack_q.size() > 0) ? nack_q.pop_front() : 1'b0;
						end
					end
				end
			end
			else if (active && !scl_i && scl_d)
			begin
				if (ack_slot)
				begin
					ack_slot = 1'b0;
					bitcnt = 0;
					if (addr_phase)
					begin
						rd_mode = sh[0];  // r/w bit of the address
						addr_phase = 1'b0;
					end
					if (rd_mode && !nack)
					begin
						tx = (rd_q.size() > 0) ? rd_q.pop_front() : 8'hff;
						sda_drv <= !tx[7];
					end
					else
						sda_drv <= 1'b0;
				end
				else if (bitcnt == 8)
				begin
					ack_slot = 1'b1;
					sda_drv <= !rd_mode && !nack;  // release for the master's ack on reads
				end
				else if (rd_mode && bitcnt > 0)
					sda_drv <= !tx[7 - bitcnt];
				// master low phase is about ten cycles so longer holds stretch
				rv = $random(seed);
				hold <= rv[0] ? 10 + int'(rv[3:1]) % 7 : 0;
			end
			scl_d = scl_i;
			sda_d = sda_i;
		end
	end

endmodule

/* verif/tb_i2c_master.sv */
`timescale 1ns/100ps
`include "i2c_consts.svh"

module tb_i2c_master;
	import i2c_pkg::*;

	localparam int CLK_CNT   = 3;
	localparam int N_TRANS   = 12;
	localparam int MAX_BYTES = N_TRANS * 5 + 2;  // address plus up to four data bytes
	localparam int WD_CYCLES = 2 * MAX_BYTES * 10 * 4 * (CLK_CNT + 1) * 2 + 2000;

	logic                  clk;
	logic                  nReset;
	logic                  ena;
	logic [`I2C_CNT_W-1:0] clk_cnt;
	byte_cmd_t             cmd;
	logic                  cmd_ack_o;
	byte_rsp_t             rsp_o;
	logic                  busy_o, al_o, bus_busy_o;
	logic                  scl_oen_o, sda_oen_o;
	logic                  slv_scl_low, slv_sda_low;
	logic                  force_low;
	wire                   scl, sda;
	integer                seed;
	logic [`I2C_DATA_W-1:0] exp_wr[$];
	logic                  exp_mack[$];

	// wired-AND bus with pull-ups
	assign scl = scl_oen_o & ~slv_scl_low;
	assign sda = sda_oen_o & ~slv_sda_low;

	i2c_master_top u_i2c_master_top (
		.clk        (clk),
		.nReset     (nReset),
		.ena_i      (ena),
		.clk_cnt_i  (clk_cnt),
		.cmd_i      (cmd),
		.cmd_ack_o  (cmd_ack_o),
		.rsp_o      (rsp_o),
		.busy_o     (busy_o),
		.al_o       (al_o),
		.bus_busy_o (bus_busy_o),
		.scl_i      (scl),
		.sda_i      (sda),
		.scl_oen_o  (scl_oen_o),
		.sda_oen_o  (sda_oen_o)
	);

	i2c_slave_model u_slave (
		.clk             (clk),
		.nReset          (nReset),
		.scl_i           (scl),
		.sda_i           (sda),
		.force_sda_low_i (force_low),
		.scl_low_o       (slv_scl_low),
		.sda_low_o       (slv_sda_low)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [31:0] next_random();
		next_random = $random(seed);
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_rsp(input byte_rsp_t got, input byte_rsp_t exp);
		if (got !== exp)
			fail_run($sformatf("ERR %0t rsp_o exp=%h got=%h", $time, exp, got));
	endtask

	task automatic check_byte(input string name, input logic [`I2C_DATA_W-1:0] got,
		input logic [`I2C_DATA_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %0t %s exp=%h got=%h", $time, name, exp, got));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("ERR %0t %s exp=%b got=%b", $time, name, exp, got));
	endtask

	// hold one byte command until its cmd_ack, then check the result
	task automatic send_byte(input byte_cmd_t c, input byte_rsp_t exp);
		@(posedge clk);
		cmd <= c;
		@(negedge clk);
		check_flag("cmd_ack_o", cmd_ack_o, 1'b0);
		while (!cmd_ack_o)
		begin
			if (al_o)
				fail_run("arbitration was lost during a normal transfer");
			@(negedge clk);
		end
		check_rsp(rsp_o, exp);
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("bus_busy_o", bus_busy_o, !c.stop);
	endtask

	task automatic compare_slave_log();
		if (u_slave.rx_q.size() != exp_wr.size())
			fail_run($sformatf("slave received %0d bytes but %0d were sent",
				u_slave.rx_q.size(), exp_wr.size()));
		while (exp_wr.size() > 0)
			check_byte("slave rx byte", u_slave.rx_q.pop_front(), exp_wr.pop_front());
		if (u_slave.mack_q.size() != exp_mack.size())
			fail_run("slave saw a different number of master acks than read bytes");
		while (exp_mack.size() > 0)
			check_flag("master ack at slave", u_slave.mack_q.pop_front(), exp_mack.pop_front());
	endtask

	task automatic run_transfer();
		byte_cmd_t   c;
		byte_rsp_t   r;
		logic [31:0] rv;
		logic [7:0]  addr;
		logic [7:0]  data[4];
		logic        nks[4];
		logic        rw, nk, last;
		int          nb;
		rv = next_random();
		nb = 1 + int'(rv[17:16]);
		rw = rv[0];
		addr = {rv[7:1], rw};
		nk = rw ? 1'b0 : (rv[9:8] == 2'b00);  // reads need the address acked
		// the slave fetches a read byte at the end of the ack slot before it
		for (int k = 0; k < nb; k++)
		begin
			rv = next_random();
			data[k] = rv[7:0];
			nks[k] = (rv[9:8] == 2'b00);
			if (rw)
				u_slave.rd_q.push_back(rv[7:0]);
		end
		u_slave.nack_q.push_back(nk);
		exp_wr.push_back(addr);
		c = '{start: 1'b1, stop: 1'b0, read: 1'b0, write: 1'b1, ack_in: 1'b0, din: addr};
		r = '{ack_out: nk, dout: addr};
		send_byte(c, r);
		for (int k = 0; k < nb; k++)
		begin
			last = (k == nb - 1);
			if (!rw)
			begin
				u_slave.nack_q.push_back(nks[k]);
				exp_wr.push_back(data[k]);
				c = '{start: 1'b0, stop: last, read: 1'b0, write: 1'b1, ack_in: 1'b0,
					din: data[k]};
				r = '{ack_out: nks[k], dout: data[k]};  // write reads its own bits back
			end
			else
			begin
				exp_mack.push_back(last);  // nack only the last byte
				c = '{start: 1'b0, stop: last, read: 1'b1, write: 1'b0, ack_in: last,
					din: ~data[k]};  // din plays no part in a read
				r = '{ack_out: last, dout: data[k]};
			end
			send_byte(c, r);
		end
		@(posedge clk);
		cmd <= '0;
		compare_slave_log();
	endtask

	// slave holds sda low while the master sends ones
	task automatic arbitration_loss();
		byte_cmd_t   c;
		byte_rsp_t   r;
		logic [31:0] rv;
		logic [7:0]  addr;
		rv = next_random();
		addr = {rv[7:1], 1'b0};
		u_slave.nack_q.push_back(1'b0);
		c = '{start: 1'b1, stop: 1'b0, read: 1'b0, write: 1'b1, ack_in: 1'b0, din: addr};
		r = '{ack_out: 1'b0, dout: addr};
		send_byte(c, r);
		@(posedge clk);
		force_low <= 1'b1;
		cmd <= '{start: 1'b0, stop: 1'b1, read: 1'b0, write: 1'b1, ack_in: 1'b0, din: 8'hff};
		@(negedge clk);
		while (!al_o)
		begin
			if (cmd_ack_o)
				fail_run("command was acknowledged although arbitration should be lost");
			@(negedge clk);
		end
		check_flag("scl_oen_o", scl_oen_o, 1'b1);
		check_flag("sda_oen_o", sda_oen_o, 1'b1);
		@(posedge clk);
		cmd <= '0;
		force_low <= 1'b0;  // sda rises with scl high so the bus sees a stop
		@(negedge clk);
		check_flag("al_o", al_o, 1'b0);
		while (bus_busy_o)
		begin
			if (cmd_ack_o)
				fail_run("cmd_ack appeared after lost arbitration");
			@(negedge clk);
		end
		if (u_slave.rx_q.size() != 1)
			fail_run("slave did not log exactly the address before lost arbitration");
		check_byte("slave rx byte", u_slave.rx_q.pop_front(), addr);
	endtask

	initial
	begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, a transfer never finished", WD_CYCLES);
		$display("Testbench failed");
		$fatal(1, "timeout");
	end

	initial
	begin
		seed = 24;
		nReset = 1'b0;
		ena = 1'b1;
		clk_cnt = CLK_CNT;
		cmd = '0;
		force_low = 1'b0;
		repeat (3) @(posedge clk);
		nReset <= 1'b1;
		@(negedge clk);
		check_flag("scl_oen_o", scl_oen_o, 1'b1);
		check_flag("sda_oen_o", sda_oen_o, 1'b1);
		check_flag("bus_busy_o", bus_busy_o, 1'b0);
		check_flag("cmd_ack_o", cmd_ack_o, 1'b0);
		check_flag("al_o", al_o, 1'b0);
		check_flag("busy_o", busy_o, 1'b0);
		for (int i = 0; i < N_TRANS; i++)
		begin
			if (i == N_TRANS / 2)
				arbitration_loss();
			run_transfer();
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

/* i2c_master_top.f */
+incdir+hw
hw/i2c_pkg.sv
hw/i2c_clk_timer.sv
hw/i2c_bit_ctrl.sv
hw/i2c_shift_reg.sv
hw/i2c_byte_ctrl.sv
hw/i2c_master_top.sv
verif/i2c_slave_model.sv
verif/tb_i2c_master.sv

/* Makefile */
# Verilator build and run of the I2C master testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FILELIST  ?= i2c_master_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench passed" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
